/* backend/backendControl.sv */
/*
 * Access sequencer of the ORAM backend. Hands appends to the stash, runs the read
 * and writeback phases of a path access and inserts dummy accesses on demand.
 */
`timescale 1ns/1ns

module backendControl #(
	parameter int oramL = oramGeometry::defaultOramL
) (
	input logic Clock,
	input logic rstN,

	// Front-end command, held until commandDone
	input oramTypes::beCommandT command,
	input oramTypes::pAddrT pAddr,
	input logic [oramL-1:0] currentLeaf,
	input logic [oramL-1:0] remappedLeaf,
	input logic commandRequest,
	output logic commandDone,

	// Stash command channel
	output oramTypes::stashCommandT stashCommand,
	output logic stashCommandValid,
	input logic stashCommandReady,
	output oramTypes::beCommandT stashBeCommand,
	output oramTypes::pAddrT stashPAddr,
	output logic [oramL-1:0] stashCurrentLeaf,
	output logic [oramL-1:0] stashRemappedLeaf,
	output logic stashAccessIsDummy,
	input logic stashAlmostFull,

	// Path address generator
	output logic [oramL-1:0] genLeaf,
	output logic genWrite,
	output logic genValid,
	input logic genReady,

	// Alarms from the transfer counters
	input logic dataReadDone,
	input logic dataWriteDone,
	input logic addrWriteDone,

	// Dummy leaf source
	input logic randValid,
	input logic [oramL-1:0] randLeaf,
	output logic randReady
);

	import oramTypes::*;

	typedef enum logic [3:0] {
		Idle,
		Append,
		AppendWait,
		AddrGenRead,
		StashRead,
		Read,
		AddrGenWrite,
		StashWrite,
		Write
	} stateT;

	stateT state;
	stateT nextState;
	logic isDummy;
	logic addrDoneSeen;
	logic dataDoneSeen;
	logic operationComplete;
	logic takeDummy;
	logic takeAppend;
	logic takeAccess;
	logic [oramL-1:0] accessLeaf;

	// Command fields captured when leaving Idle
	beCommandT heldCommand;
	pAddrT heldPAddr;
	logic [oramL-1:0] heldCurrentLeaf;
	logic [oramL-1:0] heldRemappedLeaf;

	//--------------------------------------------------------------------
	// Idle decisions
	//--------------------------------------------------------------------

	// Stash pressure wins over everything
	assign takeDummy = stashAlmostFull & randValid;
	// Appends are cheap, serve them before full accesses
	assign takeAppend = ~stashAlmostFull & commandRequest & (command == beAppend);
	assign takeAccess = ~stashAlmostFull & commandRequest & (command != beAppend) & randValid;

	// Both writeback streams drained, now or earlier
	assign operationComplete = (state == Write) & (addrDoneSeen | addrWriteDone)
		& (dataDoneSeen | dataWriteDone);

	always_comb begin
		nextState = state;
		case (state)
			Idle: begin
				if (takeDummy) begin
					nextState = AddrGenRead;
				end else if (takeAppend) begin
					nextState = Append;
				end else if (takeAccess) begin
					nextState = AddrGenRead;
				end
			end
			Append: if (stashCommandReady) nextState = AppendWait;
			// Done pulses here, one cycle after the stash took the append
			AppendWait: nextState = Idle;
			AddrGenRead: if (genReady) nextState = StashRead;
			StashRead: if (stashCommandReady) nextState = Read;
			// Last read burst landed in the stash
			Read: if (dataReadDone) nextState = AddrGenWrite;
			AddrGenWrite: if (genReady) nextState = StashWrite;
			StashWrite: if (stashCommandReady) nextState = Write;
			Write: if (operationComplete) nextState = Idle;
			default: nextState = Idle;
		endcase
	end

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			state <= Idle;
			isDummy <= 1'b0;
			addrDoneSeen <= 1'b0;
			dataDoneSeen <= 1'b0;
		end else begin
			state <= nextState;
			if (state == Idle) begin
				isDummy <= takeDummy;
			end
			// Writeback alarms may come before the Write state
			if (operationComplete) begin
				addrDoneSeen <= 1'b0;
				dataDoneSeen <= 1'b0;
			end else begin
				addrDoneSeen <= addrDoneSeen | addrWriteDone;
				dataDoneSeen <= dataDoneSeen | dataWriteDone;
			end
		end
	end

	// Fields follow the front end while idle, frozen during an access
	always_ff @(posedge Clock) begin
		if (state == Idle) begin
			heldCommand <= command;
			heldPAddr <= pAddr;
			heldCurrentLeaf <= currentLeaf;
			heldRemappedLeaf <= remappedLeaf;
		end
	end

	//--------------------------------------------------------------------
	// Stash and generator outputs
	//--------------------------------------------------------------------

	// Dummy access walks the random leaf, stable until randReady
	assign accessLeaf = isDummy ? randLeaf : heldCurrentLeaf;

	always_comb begin
		case (state)
			Append: stashCommand = stAppend;
			StashRead: stashCommand = stStartRead;
			default: stashCommand = stStartWrite;
		endcase
	end

	assign stashCommandValid = (state == Append) | (state == StashRead) | (state == StashWrite);
	assign stashBeCommand = heldCommand;
	assign stashPAddr = heldPAddr;
	assign stashCurrentLeaf = accessLeaf;
	assign stashRemappedLeaf = heldRemappedLeaf;
	assign stashAccessIsDummy = isDummy;

	assign genLeaf = accessLeaf;
	assign genWrite = state == AddrGenWrite;
	assign genValid = (state == AddrGenRead) | (state == AddrGenWrite);

	// Front end hears appends and real accesses only
	assign commandDone = (state == AppendWait) | (operationComplete & ~isDummy);
	// Fresh dummy leaf for the next access
	assign randReady = operationComplete;

	// Stalled command keeps its kind and leaf, dummy leaf included
	stashHeldWhileStalled: assert property (@(posedge Clock) disable iff (!rstN)
		stashCommandValid && !stashCommandReady |=> stashCommandValid
		&& $stable(stashCommand) && $stable(stashCurrentLeaf))
		else $error("stash command changed while stalled");

	dummySilent: assert property (@(posedge Clock) disable iff (!rstN)
		isDummy |-> !commandDone)
		else $error("commandDone during dummy access");

endmodule

/* backend/leafGenerator.sv */
/*
 * Random leaf source for dummy accesses, a 16-bit Fibonacci LFSR.
 * The offered leaf is replaced one cycle after randReady.
 */
`timescale 1ns/1ns

module leafGenerator #(
	parameter int oramL = oramGeometry::defaultOramL
) (
	input logic Clock,
	input logic rstN,
	input logic randReady,
	output logic randValid,
	output logic [oramL-1:0] randLeaf
);

	typedef logic [15:0] lfsrT;

	// Any nonzero start value
	localparam lfsrT seed = 16'hace1;

	lfsrT lfsr;
	lfsrT lfsrAdvanced;

	// Taps 16, 14, 13, 11 give a maximal length sequence
	function automatic lfsrT stepLfsr(input lfsrT s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// oramL shifts so no leaf bit is reused
	always_comb begin
		lfsrAdvanced = lfsr;
		for (int i = 0; i < oramL; i++) begin
			lfsrAdvanced = stepLfsr(lfsrAdvanced);
		end
	end

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			lfsr <= seed;
			randValid <= 1'b0;
		end else begin
			randValid <= 1'b1;
			if (randValid & randReady) begin
				lfsr <= lfsrAdvanced;
			end
		end
	end

	assign randLeaf = lfsr[oramL-1:0];

endmodule

/* backend/transferCounter.sv */
/*
 * Counts one transfer stream through a path read phase and then a writeback phase.
 * An alarm pulses together with the last transfer of each phase.
 */
`timescale 1ns/1ns

module transferCounter #(
	parameter int oramL = oramGeometry::defaultOramL,
	parameter int bucketBursts = oramGeometry::defaultBucketBursts
) (
	input logic Clock,
	input logic rstN,
	input logic transfer,
	output logic readDone,
	output logic writeDone,
	output logic writePhase
);

	// Bursts on one root to leaf path
	localparam int pathBursts = (oramL + 1) * bucketBursts;
	localparam int countWidth = $clog2(pathBursts + 1);

	typedef logic [countWidth-1:0] countT;

	countT count;
	logic lastTransfer;

	// Transfer that closes the current phase
	assign lastTransfer = transfer & (count == countT'(pathBursts - 1));
	assign readDone = lastTransfer & ~writePhase;
	assign writeDone = lastTransfer & writePhase;

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			count <= '0;
			writePhase <= 1'b0;
		end else if (lastTransfer) begin
			// Read phase hands over to writeback and back again
			count <= '0;
			writePhase <= ~writePhase;
		end else if (transfer) begin
			count <= count + 1'b1;
		end
	end

	countInRange: assert property (@(posedge Clock) disable iff (!rstN)
		count < countT'(pathBursts))
		else $error("transfer count past path length");

endmodule

/* common/oramGeometry.sv */
/*
 * Default tree geometry of the Path ORAM and the burst counts derived from it.
 * The top level takes its parameter defaults from here.
 */
package oramGeometry;

	// Levels below the root, also the leaf width
	localparam int defaultOramL = 4;

	// DRAM bursts in one bucket
	localparam int defaultBucketBursts = 2;

	// Buckets on one root to leaf path
	localparam int defaultPathBuckets = defaultOramL + 1;

	// Bursts moved in one read or one writeback phase
	localparam int defaultPathBursts = defaultPathBuckets * defaultBucketBursts;

	// Whole tree in heap order, for sizing a DRAM model
	localparam int defaultTreeBuckets = (1 << (defaultOramL + 1)) - 1;
	localparam int defaultTreeBursts = defaultTreeBuckets * defaultBucketBursts;

endpackage

/* common/oramTypes.sv */
/*
 * Command encodings and address types shared by the backend RTL and its testbench.
 * Use scoped names in port lists and a wildcard import inside a module body.
 */
package oramTypes;

	// Widths of the fixed address fields
	localparam int pAddrWidth = 32;
	localparam int dramAddrWidth = 32;

	// Program block address from the front end
	typedef logic [pAddrWidth-1:0] pAddrT;

	// DRAM burst address, one per burst of a bucket
	typedef logic [dramAddrWidth-1:0] dramAddrT;

	//--------------------------------------------------------------------
	// Front-end commands
	//--------------------------------------------------------------------

	// Append costs no path access, read and write do
	typedef enum logic [1:0] {
		beWrite = 2'd0,
		beAppend = 2'd1,
		beRead = 2'd2
	} beCommandT;

	//--------------------------------------------------------------------
	// Stash commands
	//--------------------------------------------------------------------

	// StartRead and StartWrite bracket the two phases of one path access
	typedef enum logic [1:0] {
		stStartRead = 2'd0,
		stStartWrite = 2'd1,
		stAppend = 2'd2
	} stashCommandT;

endpackage

/* source/oramBackend.sv */
/*
 * Top level of the Path ORAM backend control core. Stash, DRAM and encryption
 * sit outside, their handshakes appear here as loose ports.
 */
`timescale 1ns/1ns

module oramBackend #(
	parameter int oramL = oramGeometry::defaultOramL,
	parameter int bucketBursts = oramGeometry::defaultBucketBursts
) (
	input logic Clock,
	input logic rstN,

	// Front-end command side
	input oramTypes::beCommandT command,
	input oramTypes::pAddrT pAddr,
	input logic [oramL-1:0] currentLeaf,
	input logic [oramL-1:0] remappedLeaf,
	input logic commandRequest,
	output logic commandDone,

	// Stash side
	output oramTypes::stashCommandT stashCommand,
	output logic stashCommandValid,
	input logic stashCommandReady,
	output oramTypes::beCommandT stashBeCommand,
	output oramTypes::pAddrT stashPAddr,
	output logic [oramL-1:0] stashCurrentLeaf,
	output logic [oramL-1:0] stashRemappedLeaf,
	output logic stashAccessIsDummy,
	input logic stashAlmostFull,

	// DRAM address stream and data pulses
	output oramTypes::dramAddrT dramAddr,
	output logic dramWrite,
	output logic dramAddrValid,
	input logic dramAddrReady,
	input logic dataReadTransfer,
	input logic dataWriteTransfer
);

	// Controller to generator
	logic [oramL-1:0] genLeaf;
	logic genWrite;
	logic genValid;
	logic genReady;

	// Counter alarms
	logic dataReadDone;
	logic dataWriteDone;
	logic addrWriteDone;

	// Dummy leaf handshake
	logic randValid;
	logic [oramL-1:0] randLeaf;
	logic randReady;

	logic addrTransfer;
	logic dataTransfer;

	assign addrTransfer = dramAddrValid & dramAddrReady;
	// Stash never reads and writes in the same phase
	assign dataTransfer = dataReadTransfer | dataWriteTransfer;

	backendControl #(.oramL(oramL)) control (.*);

	// Address stream, only the writeback end matters
	transferCounter #(.oramL(oramL), .bucketBursts(bucketBursts)) addrCounter (
		.Clock(Clock),
		.rstN(rstN),
		.transfer(addrTransfer),
		.readDone(),
		.writeDone(addrWriteDone),
		.writePhase()
	);

	// Data bursts between stash and DRAM
	transferCounter #(.oramL(oramL), .bucketBursts(bucketBursts)) dataCounter (
		.Clock(Clock),
		.rstN(rstN),
		.transfer(dataTransfer),
		.readDone(dataReadDone),
		.writeDone(dataWriteDone),
		.writePhase()
	);

	leafGenerator #(.oramL(oramL)) leafGen (.*);

	pathAddrGen #(.oramL(oramL), .bucketBursts(bucketBursts)) addrGen (.*);

endmodule

/* source/pathAddrGen.sv */
/*
 * Expands a leaf into the DRAM burst addresses of every bucket on its path,
 * root first. Accepts a new leaf only while idle.
 */
`timescale 1ns/1ns

module pathAddrGen #(
	parameter int oramL = oramGeometry::defaultOramL,
	parameter int bucketBursts = oramGeometry::defaultBucketBursts
) (
	input logic Clock,
	input logic rstN,

	// Leaf request from the controller
	input logic [oramL-1:0] genLeaf,
	input logic genWrite,
	input logic genValid,
	output logic genReady,

	// Burst address stream toward DRAM
	output oramTypes::dramAddrT dramAddr,
	output logic dramWrite,
	output logic dramAddrValid,
	input logic dramAddrReady
);

	import oramTypes::*;

	localparam int levelWidth = $clog2(oramL + 1);
	localparam int burstWidth = (bucketBursts > 1) ? $clog2(bucketBursts) : 1;

	typedef logic [levelWidth-1:0] levelT;
	typedef logic [burstWidth-1:0] burstT;

	logic busy;
	levelT level;
	burstT burst;
	logic [oramL-1:0] leaf;
	logic addrTransfer;
	logic lastBurst;
	logic lastLevel;
	dramAddrT levelBase;
	dramAddrT bucketIndex;

	assign genReady = ~busy;
	assign dramAddrValid = busy;
	assign addrTransfer = dramAddrValid & dramAddrReady;
	assign lastBurst = burst == burstT'(bucketBursts - 1);
	assign lastLevel = level == levelT'(oramL);

	// Heap order, level k starts at bucket 2^k - 1
	assign levelBase = (dramAddrT'(1) << level) - dramAddrT'(1);
	// Top k leaf bits pick the node within the level
	assign bucketIndex = levelBase + (dramAddrT'(leaf) >> (levelT'(oramL) - level));
	// Held by the registers while ready is low
	assign dramAddr = bucketIndex * dramAddrT'(bucketBursts) + dramAddrT'(burst);

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			busy <= 1'b0;
			level <= '0;
			burst <= '0;
		end else if (genValid & genReady) begin
			busy <= 1'b1;
			level <= '0;
			burst <= '0;
		end else if (addrTransfer) begin
			if (lastBurst) begin
				burst <= '0;
				// Leaf bucket done, path finished
				if (lastLevel) begin
					busy <= 1'b0;
				end else begin
					level <= level + 1'b1;
				end
			end else begin
				burst <= burst + 1'b1;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (genValid & genReady) begin
			leaf <= genLeaf;
			dramWrite <= genWrite;
		end
	end

	// Controller offers a leaf only once the previous path has drained
	noLeafWhileStreaming: assert property (@(posedge Clock) disable iff (!rstN)
		!(genValid && dramAddrValid))
		else $error("leaf offered while streaming addresses");

endmodule

/* sources.f */
common/oramTypes.sv
common/oramGeometry.sv
backend/transferCounter.sv
backend/leafGenerator.sv
backend/backendControl.sv
source/pathAddrGen.sv
source/oramBackend.sv
tests/oramBackendTb.sv

/* tests/oramBackendTb.sv */
/*
 * Testbench of the ORAM backend core. Drives random front-end commands, models the
 * stash and DRAM side, and checks stash commands and burst addresses against a path model.
 */
`timescale 1ns/1ns

module oramBackendTb;

	import oramTypes::*;

	localparam int oramL = oramGeometry::defaultOramL;
	localparam int bucketBursts = oramGeometry::defaultBucketBursts;
	localparam int pathBursts = (oramL + 1) * bucketBursts;
	localparam int numCommands = 60;
	localparam int maxStall = 16;
	// Worst case per command covers a dummy access plus the real one
	localparam int cycleLimit = numCommands * 4 * pathBursts * maxStall;

	logic Clock;
	logic rstN;
	beCommandT command;
	pAddrT pAddr;
	logic [oramL-1:0] currentLeaf;
	logic [oramL-1:0] remappedLeaf;
	logic commandRequest;
	logic commandDone;
	stashCommandT stashCommand;
	logic stashCommandValid;
	logic stashCommandReady;
	beCommandT stashBeCommand;
	pAddrT stashPAddr;
	logic [oramL-1:0] stashCurrentLeaf;
	logic [oramL-1:0] stashRemappedLeaf;
	logic stashAccessIsDummy;
	logic stashAlmostFull;
	dramAddrT dramAddr;
	logic dramWrite;
	logic dramAddrValid;
	logic dramAddrReady;
	logic dataReadTransfer;
	logic dataWriteTransfer;

	// Reference model, expected stash commands in issue order
	stashCommandT expCmd[$];
	logic expDummy[$];
	beCommandT expBeCmd[$];
	pAddrT expPAddr[$];
	logic [oramL-1:0] expCurLeaf[$];
	logic [oramL-1:0] expRemLeaf[$];
	// Expected bursts as {write, address}
	logic [32:0] expAddr[$];

	logic [31:0] lfsrState = 32'h1f79_ec00;
	int valueErrors = 0;
	int protocolErrors = 0;
	int resetCycles = 0;
	int issued = 0;
	int completed = 0;
	int gap = 4;
	int pendingRead = 0;
	int pendingWrite = 0;
	logic doneSeen = 1'b0;
	logic dummyStarted = 1'b0;
	logic stashStalled = 1'b0;
	logic addrStalled = 1'b0;
	logic appendAccepted = 1'b0;
	logic [oramL-1:0] accessLeaf;
	logic [2*oramL+36:0] stashBundle;
	logic [2*oramL+36:0] stashHeld;
	logic [32:0] addrHeld;

	assign stashBundle = {stashCommand, stashBeCommand, stashAccessIsDummy, stashPAddr,
		stashCurrentLeaf, stashRemappedLeaf};

	oramBackend #(.oramL(oramL), .bucketBursts(bucketBursts)) oramBackend_inst (.*);

	initial begin
		Clock = 1'b0;
		forever #20 Clock = ~Clock;
	end

	// 32-bit Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	task automatic reportMismatch(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		$display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, expected);
		valueErrors++;
	endtask

	task automatic reportProblem(input string what);
		$display("Error at %0t ns: %s", $time, what);
		protocolErrors++;
	endtask

	task automatic finishRun();
		$display("Errors: %0d value mismatches, %0d protocol errors", valueErrors,
			protocolErrors);
		if (valueErrors == 0 && protocolErrors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	endtask

	// Heap-ordered buckets from root to leaf, all bursts of each bucket
	task automatic pushPath(input logic [oramL-1:0] leaf, input logic write);
		int bucket;
		for (int k = 0; k <= oramL; k++) begin
			bucket = (1 << k) - 1 + (int'(leaf) >> (oramL - k));
			for (int b = 0; b < bucketBursts; b++) begin
				expAddr.push_back({write, 32'(bucket * bucketBursts + b)});
			end
		end
	endtask

	task automatic pushCommand(input stashCommandT cmd, input logic dummy);
		expCmd.push_back(cmd);
		expDummy.push_back(dummy);
		expBeCmd.push_back(command);
		expPAddr.push_back(pAddr);
		expCurLeaf.push_back(currentLeaf);
		expRemLeaf.push_back(remappedLeaf);
	endtask

	task automatic issueCommand();
		logic [1:0] kind;
		kind = 2'(randBits(2));
		pAddr = randBits(32);
		currentLeaf = oramL'(randBits(oramL));
		remappedLeaf = oramL'(randBits(oramL));
		case (kind)
			2'd0: command = beAppend;
			2'd1: command = beWrite;
			default: command = beRead;
		endcase
		// Almost-full episode, one dummy access goes first
		if (randBits(2) == 32'd0) begin
			stashAlmostFull = 1'b1;
			pushCommand(stStartRead, 1'b1);
			pushCommand(stStartWrite, 1'b1);
		end
		if (command == beAppend) begin
			pushCommand(stAppend, 1'b0);
		end else begin
			pushCommand(stStartRead, 1'b0);
			pushCommand(stStartWrite, 1'b0);
		end
		commandRequest = 1'b1;
		issued++;
	endtask

	// First sight of a stash command, compared and then retired from the model
	task automatic checkStashCommand();
		if (expCmd.size() == 0) begin
			reportProblem("stash command presented with none expected");
		end else begin
			if (stashCommand !== expCmd[0]) reportMismatch("stashCommand", stashCommand, expCmd[0]);
			if (stashAccessIsDummy !== expDummy[0]) begin
				reportMismatch("stashAccessIsDummy", stashAccessIsDummy, expDummy[0]);
			end
			if (!expDummy[0]) begin
				if (stashBeCommand !== expBeCmd[0]) begin
					reportMismatch("stashBeCommand", stashBeCommand, expBeCmd[0]);
				end
				if (stashPAddr !== expPAddr[0]) reportMismatch("stashPAddr", stashPAddr, expPAddr[0]);
				if (stashCurrentLeaf !== expCurLeaf[0]) begin
					reportMismatch("stashCurrentLeaf", stashCurrentLeaf, expCurLeaf[0]);
				end
				if (stashRemappedLeaf !== expRemLeaf[0]) begin
					reportMismatch("stashRemappedLeaf", stashRemappedLeaf, expRemLeaf[0]);
				end
			end
			// Dummy leaf is only known once presented
			if (expCmd[0] == stStartRead) begin
				accessLeaf = expDummy[0] ? stashCurrentLeaf : expCurLeaf[0];
				pushPath(accessLeaf, 1'b0);
			end else if (expCmd[0] == stStartWrite) begin
				if (stashCurrentLeaf !== accessLeaf) begin
					reportMismatch("stashCurrentLeaf", stashCurrentLeaf, accessLeaf);
				end
				pushPath(accessLeaf, 1'b1);
			end
			void'(expCmd.pop_front());
			void'(expDummy.pop_front());
			void'(expBeCmd.pop_front());
			void'(expPAddr.pop_front());
			void'(expCurLeaf.pop_front());
			void'(expRemLeaf.pop_front());
		end
	endtask

	//----------------------------------------------------------------------
	// Stimulus, front end plus stash and DRAM responses
	//----------------------------------------------------------------------

	always @(posedge Clock) begin
		#2;
		if (!rstN) begin
			resetCycles++;
			if (resetCycles == 10) rstN = 1'b1;
		end else begin
			// Ready three cycles in four
			stashCommandReady = randBits(2) != 32'd0;
			dramAddrReady = randBits(2) != 32'd0;
			// One data pulse per accepted burst, random delay
			dataReadTransfer = 1'b0;
			dataWriteTransfer = 1'b0;
			if (pendingRead > 0 && randBits(1) != 32'd0) begin
				dataReadTransfer = 1'b1;
				pendingRead--;
			end else if (pendingWrite > 0 && randBits(1) != 32'd0) begin
				dataWriteTransfer = 1'b1;
				pendingWrite--;
			end
			if (dummyStarted) begin
				stashAlmostFull = 1'b0;
				dummyStarted = 1'b0;
			end
			if (doneSeen) begin
				commandRequest = 1'b0;
				doneSeen = 1'b0;
				gap = randBits(2);
			end else if (gap > 0) begin
				gap--;
			end else if (!commandRequest && issued < numCommands) begin
				issueCommand();
			end
		end
	end

	//----------------------------------------------------------------------
	// Monitor, sampled mid-cycle while outputs are settled
	//----------------------------------------------------------------------

	always @(negedge Clock) begin
		if (rstN === 1'b1) begin
			if (issued == 0 && (commandDone || stashCommandValid || dramAddrValid)) begin
				reportProblem("DUT output active before any request");
			end
			// Stash channel, stalled fields must hold
			if (stashStalled) begin
				if (!stashCommandValid) reportProblem("stash command withdrawn while stalled");
				if (stashBundle !== stashHeld) reportMismatch("stash fields", stashBundle, stashHeld);
			end else if (stashCommandValid) begin
				checkStashCommand();
			end
			if (stashCommandValid && stashCommandReady && stashAccessIsDummy
				&& stashCommand == stStartRead) begin
				dummyStarted = 1'b1;
			end
			stashStalled = stashCommandValid && !stashCommandReady;
			stashHeld = stashBundle;
			// Append completes one cycle after the stash takes it
			if (appendAccepted && commandDone !== 1'b1) begin
				reportMismatch("commandDone", commandDone, 1'b1);
			end
			appendAccepted = stashCommandValid && stashCommandReady && stashCommand == stAppend;
			// DRAM address channel
			if (addrStalled) begin
				if (!dramAddrValid) reportProblem("DRAM address withdrawn while stalled");
				if ({dramWrite, dramAddr} !== addrHeld) begin
					reportMismatch("dramWrite and dramAddr", {dramWrite, dramAddr}, addrHeld);
				end
			end
			if (dramAddrValid && dramAddrReady) begin
				if (expAddr.size() == 0) begin
					reportProblem("DRAM address transferred with none expected");
				end else begin
					if ({dramWrite, dramAddr} !== expAddr[0]) begin
						reportMismatch("dramWrite and dramAddr", {dramWrite, dramAddr}, expAddr[0]);
					end
					void'(expAddr.pop_front());
				end
				if (dramWrite) pendingWrite++;
				else pendingRead++;
			end
			addrStalled = dramAddrValid && !dramAddrReady;
			addrHeld = {dramWrite, dramAddr};
			// Completion, once per request and only after its last transfer
			if (commandDone) begin
				if (!commandRequest || doneSeen) begin
					reportProblem("commandDone without an outstanding request");
				end else begin
					if (expCmd.size() != 0 || expAddr.size() != 0) begin
						reportProblem("commandDone before the access finished");
					end
					doneSeen = 1'b1;
					completed++;
				end
			end
		end
	end

	initial begin
		rstN = 1'b0;
		command = beRead;
		pAddr = '0;
		currentLeaf = '0;
		remappedLeaf = '0;
		commandRequest = 1'b0;
		stashCommandReady = 1'b0;
		stashAlmostFull = 1'b0;
		dramAddrReady = 1'b0;
		dataReadTransfer = 1'b0;
		dataWriteTransfer = 1'b0;
		wait (completed == numCommands);
		// Catch late extra completions
		repeat (8) @(negedge Clock);
		if (expCmd.size() != 0 || expAddr.size() != 0) begin
			reportProblem("run ended with stash commands or addresses still expected");
		end
		finishRun();
	end

	initial begin
		repeat (cycleLimit) @(posedge Clock);
		reportProblem("timeout, not all commands completed");
		finishRun();
	end

endmodule
